/* common/icache_cfg_pkg.sv */
// Instruction cache bypass configuration
// Widths, counts and queue depths shared by the fetch unit, the buffers
// and the refill engine

package icache_cfg_pkg;

  // Fetch side
  localparam int unsigned NR_FETCH_PORTS = 2;
  localparam int unsigned FETCH_AW       = 32;
  localparam int unsigned FETCH_DW       = 32;
  localparam int unsigned PORT_IDX_W     = 1;

  // Line and memory beat geometry
  localparam int unsigned FILL_DW        = 64;
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned LINE_ALIGN     = 4;
  localparam int unsigned FETCH_ALIGN    = 2;
  localparam int unsigned FILL_ALIGN     = $clog2(FILL_DW / 8);
  localparam int unsigned BEATS_PER_LINE = 2;
  localparam int unsigned BEAT_CNT_W     = 1;

  // Outstanding traffic limits
  localparam int unsigned MAX_PENDING_LINES = 2;
  localparam int unsigned PENDING_CNT_W     = $clog2(MAX_PENDING_LINES + 1);
  localparam int unsigned ORDER_DEPTH       = 4;
  localparam int unsigned ORDER_PTR_W       = $clog2(ORDER_DEPTH);
  localparam int unsigned ORDER_CNT_W       = $clog2(ORDER_DEPTH + 1);

endpackage

/* common/icache_types_pkg.sv */
// Instruction cache bypass payload types
// Packed structs carried on the fetch ports, the line refill streams
// and the memory beat port

package icache_types_pkg;

  import icache_cfg_pkg::*;

  // Word returned to a fetch port together with the bus error flag
  typedef struct packed {
    logic [FETCH_DW-1:0] data;
    logic                error;
  } fetch_rsp_t;

  // Line-aligned refill request
  typedef struct packed {
    logic [FETCH_AW-1:0] addr;
  } refill_req_t;

  // Complete line with the OR of the error bits of all its beats
  typedef struct packed {
    logic [LINE_WIDTH-1:0] data;
    logic                  error;
  } refill_rsp_t;

  // Beat-aligned memory request
  typedef struct packed {
    logic [FETCH_AW-1:0] addr;
  } mem_req_t;

  // One memory beat
  typedef struct packed {
    logic [FILL_DW-1:0] data;
    logic               error;
  } mem_rsp_t;

endpackage

/* verilog/spill_register.sv */
// Spill register
// Two-slot valid/ready buffer that registers both the data and the ready
// path, giving full throughput with one cycle of latency

`timescale 1ns/100ps

module spill_register
  import icache_cfg_pkg::*;
#(
  parameter type T = logic [FETCH_AW-1:0]
) (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,

  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes every accepted input, slot B catches A when the output stalls
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign ready_o = !a_full_q || !b_full_q;
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older entry, so it goes out first
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // A stalled output must keep presenting the same entry
  a_stable_under_stall: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  );

endmodule

/* bypass/bypass_fetch.sv */
// Bypass fetch unit
// Turns single-word fetches from each port into line refill requests,
// tracks the owning port of every refill and returns the selected word
// to that port for one cycle

`timescale 1ns/100ps

module bypass_fetch
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic       [NR_FETCH_PORTS-1:0]               inst_valid_i,
  input  logic       [NR_FETCH_PORTS-1:0][FETCH_AW-1:0] inst_addr_i,
  output logic       [NR_FETCH_PORTS-1:0]               inst_ready_o,
  output fetch_rsp_t [NR_FETCH_PORTS-1:0]               inst_rsp_o,

  output logic        req_valid_o,
  output refill_req_t req_o,
  input  logic        req_ready_i,

  input  logic        rsp_valid_i,
  input  refill_rsp_t rsp_i,
  output logic        rsp_ready_o
);

  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } state_e;

  logic [NR_FETCH_PORTS-1:0] in_valid;
  logic [NR_FETCH_PORTS-1:0] in_ready;
  logic [NR_FETCH_PORTS-1:0] rsp_valid;

  logic [PORT_IDX_W-1:0]     rr_q;
  logic [PORT_IDX_W-1:0]     gnt_idx;
  logic [NR_FETCH_PORTS-1:0] gnt_onehot;
  logic                      lock_q;
  logic [PORT_IDX_W-1:0]     lock_idx_q;
  logic                      req_fire;

  logic [NR_FETCH_PORTS-1:0] order_mem_q [ORDER_DEPTH];
  logic [ORDER_PTR_W-1:0]    wr_ptr_q;
  logic [ORDER_PTR_W-1:0]    rd_ptr_q;
  logic [ORDER_CNT_W-1:0]    order_cnt_q;
  logic                      order_full;
  logic [NR_FETCH_PORTS-1:0] order_head;

  // Round-robin grant starting at rr_q. A stalled grant stays locked so the
  // request payload cannot change until the buffer takes it
  always_comb begin
    int   cand;
    logic found;
    found   = 1'b0;
    gnt_idx = rr_q;
    for (int k = 0; k < NR_FETCH_PORTS; k++) begin
      cand = (int'(rr_q) + k) % NR_FETCH_PORTS;
      if (!found && in_valid[cand]) begin
        found   = 1'b1;
        gnt_idx = PORT_IDX_W'(cand);
      end
    end
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end
    gnt_onehot          = '0;
    gnt_onehot[gnt_idx] = 1'b1;
  end

  assign req_valid_o = in_valid[gnt_idx];
  assign req_o.addr  = {inst_addr_i[gnt_idx][FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign req_fire    = req_valid_o && req_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= req_valid_o && !req_ready_i;
      lock_idx_q <= gnt_idx;
      if (req_fire) begin
        rr_q <= PORT_IDX_W'((int'(gnt_idx) + 1) % NR_FETCH_PORTS);
      end
    end
  end

  // Order queue holding the one-hot owner of every refill in flight
  assign order_full  = (order_cnt_q == ORDER_CNT_W'(ORDER_DEPTH));
  assign order_head  = order_mem_q[rd_ptr_q];
  assign rsp_ready_o = 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      order_cnt_q <= '0;
    end else begin
      if (req_fire) begin
        wr_ptr_q <= (wr_ptr_q == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rsp_valid_i) begin
        rd_ptr_q <= (rd_ptr_q == ORDER_PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({req_fire, rsp_valid_i})
        2'b10:   order_cnt_q <= order_cnt_q + 1'b1;
        2'b01:   order_cnt_q <= order_cnt_q - 1'b1;
        default: order_cnt_q <= order_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      order_mem_q[wr_ptr_q] <= gnt_onehot;
    end
  end

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_port
    state_e     state_q;
    state_e     state_d;
    fetch_rsp_t word_q;
    logic [LINE_ALIGN-FETCH_ALIGN-1:0] word_off;

    // Only request while the order queue can still record the owner
    assign in_valid[i]     = (state_q == RequestData) && !order_full;
    assign in_ready[i]     = req_ready_i && (gnt_idx == PORT_IDX_W'(i));
    assign rsp_valid[i]    = rsp_valid_i && order_head[i];
    assign inst_ready_o[i] = (state_q == PresentResponse);
    assign inst_rsp_o[i]   = word_q;
    assign word_off        = inst_addr_i[i][LINE_ALIGN-1:FETCH_ALIGN];

    always_comb begin
      state_d = state_q;
      unique case (state_q)
        Idle:            if (inst_valid_i[i]) state_d = RequestData;
        RequestData:     if (in_valid[i] && in_ready[i]) state_d = WaitResponse;
        WaitResponse:    if (rsp_valid[i]) state_d = PresentResponse;
        PresentResponse: state_d = Idle;
        default:         state_d = Idle;
      endcase
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= Idle;
      end else begin
        state_q <= state_d;
      end
    end

    // The fetch address is held until ready, so it still selects the word here
    always_ff @(posedge clk_i) begin
      if (rsp_valid[i]) begin
        word_q.data  <= rsp_i.data[word_off*FETCH_DW +: FETCH_DW];
        word_q.error <= rsp_i.error;
      end
    end
  end

  // Every returning line must have an owner recorded at request time
  a_rsp_has_owner: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> order_cnt_q != '0
  );

endmodule

/* refill/line_refill.sv */
// Line refill engine
// Splits line requests into memory beat requests, bounds the number of
// lines in flight and reassembles returning beats into full lines

`timescale 1ns/100ps

module line_refill
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic        req_valid_i,
  input  refill_req_t req_i,
  output logic        req_ready_o,

  output logic        rsp_valid_o,
  output refill_rsp_t rsp_o,
  input  logic        rsp_ready_i,

  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_req_ready_i,

  input  logic        mem_rsp_valid_i,
  input  mem_rsp_t    mem_rsp_i,
  output logic        mem_rsp_ready_o
);

  logic                      busy_q;
  logic [FETCH_AW-1:0]       line_addr_q;
  logic [BEAT_CNT_W-1:0]     req_beat_q;
  logic [PENDING_CNT_W-1:0]  pending_q;
  logic [BEAT_CNT_W-1:0]     rsp_beat_q;
  logic [LINE_WIDTH-1:0]     line_q;
  logic                      err_q;
  logic                      out_valid_q;

  logic req_fire;
  logic mem_req_fire;
  logic mem_rsp_fire;
  logic line_done;

  assign req_ready_o  = !busy_q && (pending_q < PENDING_CNT_W'(MAX_PENDING_LINES));
  assign req_fire     = req_valid_i && req_ready_o;
  assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
  assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
  assign line_done    = rsp_valid_o && rsp_ready_i;

  // Beat address is the line address with the beat index in the offset bits
  assign mem_req_valid_o = busy_q;
  assign mem_req_o.addr  = {line_addr_q[FETCH_AW-1:LINE_ALIGN], req_beat_q,
                            {FILL_ALIGN{1'b0}}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      req_beat_q <= '0;
    end else if (req_fire) begin
      busy_q     <= 1'b1;
      req_beat_q <= '0;
    end else if (mem_req_fire) begin
      if (req_beat_q == BEAT_CNT_W'(BEATS_PER_LINE - 1)) begin
        busy_q <= 1'b0;
      end
      req_beat_q <= req_beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      line_addr_q <= req_i.addr;
    end
  end

  // A line counts as pending from acceptance until it leaves the output
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      case ({req_fire, line_done})
        2'b10:   pending_q <= pending_q + 1'b1;
        2'b01:   pending_q <= pending_q - 1'b1;
        default: pending_q <= pending_q;
      endcase
    end
  end

  // Beats shift in from the top, so beat 0 ends up in the low bits
  assign mem_rsp_ready_o = !out_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_beat_q  <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (line_done) begin
        out_valid_q <= 1'b0;
      end
      if (mem_rsp_fire) begin
        rsp_beat_q <= rsp_beat_q + 1'b1;
        if (rsp_beat_q == BEAT_CNT_W'(BEATS_PER_LINE - 1)) begin
          rsp_beat_q  <= '0;
          out_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_fire) begin
      line_q <= {mem_rsp_i.data, line_q[LINE_WIDTH-1:FILL_DW]};
      err_q  <= (rsp_beat_q == '0) ? mem_rsp_i.error : (err_q | mem_rsp_i.error);
    end
  end

  assign rsp_valid_o = out_valid_q;
  assign rsp_o.data  = line_q;
  assign rsp_o.error = err_q;

  a_pending_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pending_q <= PENDING_CNT_W'(MAX_PENDING_LINES)
  );

endmodule

/* verilog/icache_bypass_top.sv */
// Instruction cache bypass top level
// Fetch unit, request and response pipeline buffers and the line refill
// engine facing a valid/ready memory port

`timescale 1ns/100ps

module icache_bypass_top
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic       [NR_FETCH_PORTS-1:0]               inst_valid_i,
  input  logic       [NR_FETCH_PORTS-1:0][FETCH_AW-1:0] inst_addr_i,
  output logic       [NR_FETCH_PORTS-1:0]               inst_ready_o,
  output fetch_rsp_t [NR_FETCH_PORTS-1:0]               inst_rsp_o,

  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_req_ready_i,

  input  logic     mem_rsp_valid_i,
  input  mem_rsp_t mem_rsp_i,
  output logic     mem_rsp_ready_o
);

  refill_req_t fetch_req;
  logic        fetch_req_valid;
  logic        fetch_req_ready;
  refill_req_t buf_req;
  logic        buf_req_valid;
  logic        buf_req_ready;

  refill_rsp_t refill_rsp;
  logic        refill_rsp_valid;
  logic        refill_rsp_ready;
  refill_rsp_t buf_rsp;
  logic        buf_rsp_valid;
  logic        buf_rsp_ready;

  bypass_fetch u_fetch (
    .clk_i        ( clk_i           ),
    .rst_n_i      ( rst_n_i         ),
    .inst_valid_i ( inst_valid_i    ),
    .inst_addr_i  ( inst_addr_i     ),
    .inst_ready_o ( inst_ready_o    ),
    .inst_rsp_o   ( inst_rsp_o      ),
    .req_valid_o  ( fetch_req_valid ),
    .req_o        ( fetch_req       ),
    .req_ready_i  ( fetch_req_ready ),
    .rsp_valid_i  ( buf_rsp_valid   ),
    .rsp_i        ( buf_rsp         ),
    .rsp_ready_o  ( buf_rsp_ready   )
  );

  spill_register #(
    .T ( refill_req_t )
  ) u_req_buf (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .valid_i ( fetch_req_valid ),
    .ready_o ( fetch_req_ready ),
    .data_i  ( fetch_req       ),
    .valid_o ( buf_req_valid   ),
    .ready_i ( buf_req_ready   ),
    .data_o  ( buf_req         )
  );

  spill_register #(
    .T ( refill_rsp_t )
  ) u_rsp_buf (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .valid_i ( refill_rsp_valid ),
    .ready_o ( refill_rsp_ready ),
    .data_i  ( refill_rsp       ),
    .valid_o ( buf_rsp_valid    ),
    .ready_i ( buf_rsp_ready    ),
    .data_o  ( buf_rsp          )
  );

  line_refill u_refill (
    .clk_i           ( clk_i            ),
    .rst_n_i         ( rst_n_i          ),
    .req_valid_i     ( buf_req_valid    ),
    .req_i           ( buf_req          ),
    .req_ready_o     ( buf_req_ready    ),
    .rsp_valid_o     ( refill_rsp_valid ),
    .rsp_o           ( refill_rsp       ),
    .rsp_ready_i     ( refill_rsp_ready ),
    .mem_req_valid_o ( mem_req_valid_o  ),
    .mem_req_o       ( mem_req_o        ),
    .mem_req_ready_i ( mem_req_ready_i  ),
    .mem_rsp_valid_i ( mem_rsp_valid_i  ),
    .mem_rsp_i       ( mem_rsp_i        ),
    .mem_rsp_ready_o ( mem_rsp_ready_o  )
  );

endmodule

/* testbench/tb_mem_model.sv */
// Memory responder for the refill port
// Accepts beat requests with random stalls and returns each beat in
// request order after a random latency, using a fixed data rule

`timescale 1ns/100ps

module tb_mem_model
  import icache_cfg_pkg::*;
  import icache_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     mem_req_valid_i,
  input  mem_req_t mem_req_i,
  output logic     mem_req_ready_o,
  output logic     mem_rsp_valid_o,
  output mem_rsp_t mem_rsp_o,
  input  logic     mem_rsp_ready_i
);

  localparam logic [FETCH_AW-1:0] DATA_KEY    = 32'h5a5a_0000;
  localparam int unsigned         MAX_LATENCY = 5;

  logic                req_ready_q = 1'b0;
  logic                rsp_valid_q = 1'b0;
  mem_rsp_t            rsp_q       = '0;
  logic [FETCH_AW-1:0] addr_q [$];
  int unsigned         due_q [$];
  int unsigned         cycle_q     = 0;

  // Each word is its own byte address XORed with the key. Addresses in the
  // upper half of the space answer with the error bit set
  function automatic mem_rsp_t beat_at(input logic [FETCH_AW-1:0] addr);
    mem_rsp_t beat;
    beat.data  = {(addr + 32'd4) ^ DATA_KEY, addr ^ DATA_KEY};
    beat.error = addr[FETCH_AW-1];
    return beat;
  endfunction

  always @(posedge clk_i) begin
    logic busy;
    if (!rst_n_i) begin
      req_ready_q <= 1'b0;
      rsp_valid_q <= 1'b0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cycle_q = cycle_q + 1;
      if (mem_req_valid_i && req_ready_q) begin
        addr_q.push_back(mem_req_i.addr);
        due_q.push_back(cycle_q + ($urandom % (MAX_LATENCY + 1)));
      end
      // A beat on offer stays put until the DUT takes it
      busy = rsp_valid_q && !mem_rsp_ready_i;
      if (!busy) begin
        if (addr_q.size() > 0 && due_q[0] <= cycle_q) begin
          rsp_valid_q <= 1'b1;
          rsp_q       <= beat_at(addr_q.pop_front());
          void'(due_q.pop_front());
        end else begin
          rsp_valid_q <= 1'b0;
        end
      end
      // Ready is low about one cycle in four
      req_ready_q <= ($urandom % 4) != 0;
    end
  end

  assign mem_req_ready_o = req_ready_q;
  assign mem_rsp_valid_o = rsp_valid_q;
  assign mem_rsp_o       = rsp_q;

endmodule

/* testbench/tb_icache_bypass.sv */
// Testbench for the instruction cache bypass path
// Directed fetch tests on both ports against a randomly stalling memory,
// with word checks derived from the memory data rule

`timescale 1ns/100ps

module tb_icache_bypass;

  import icache_cfg_pkg::*;
  import icache_types_pkg::*;

  localparam logic [FETCH_AW-1:0] DATA_KEY     = 32'h5a5a_0000;
  localparam int unsigned         RAND_FETCHES = 30;
  // About 40 fetches at up to 40 cycles each, plus reset and margin
  localparam int unsigned         TIMEOUT_CYCLES = 3000;

  logic                                 clk;
  logic                                 rst_n;
  logic [NR_FETCH_PORTS-1:0]               inst_valid;
  logic [NR_FETCH_PORTS-1:0][FETCH_AW-1:0] inst_addr;
  logic [NR_FETCH_PORTS-1:0]               inst_ready;
  fetch_rsp_t [NR_FETCH_PORTS-1:0]         inst_rsp;
  logic                                 mem_req_valid;
  mem_req_t                             mem_req;
  logic                                 mem_req_ready;
  logic                                 mem_rsp_valid;
  mem_rsp_t                             mem_rsp;
  logic                                 mem_rsp_ready;

  int unsigned err_cnt   = 0;
  int unsigned check_cnt = 0;
  int unsigned cycle_cnt = 0;

  icache_bypass_top u_dut (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .inst_valid_i    ( inst_valid    ),
    .inst_addr_i     ( inst_addr     ),
    .inst_ready_o    ( inst_ready    ),
    .inst_rsp_o      ( inst_rsp      ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_o       ( mem_req       ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       ),
    .mem_rsp_ready_o ( mem_rsp_ready )
  );

  tb_mem_model u_mem (
    .clk_i           ( clk           ),
    .rst_n_i         ( rst_n         ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_req_i       ( mem_req       ),
    .mem_req_ready_o ( mem_req_ready ),
    .mem_rsp_valid_o ( mem_rsp_valid ),
    .mem_rsp_o       ( mem_rsp       ),
    .mem_rsp_ready_i ( mem_rsp_ready )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Expected word for a fetch address under the memory data rule
  function automatic fetch_rsp_t mem_rule_word(input logic [FETCH_AW-1:0] addr);
    fetch_rsp_t word;
    word.data  = {addr[FETCH_AW-1:FETCH_ALIGN], {FETCH_ALIGN{1'b0}}} ^ DATA_KEY;
    word.error = addr[FETCH_AW-1];
    return word;
  endfunction

  task automatic check_fetch(input string name, input fetch_rsp_t expected,
                             input fetch_rsp_t actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("[ERROR] %s: expected data=%08h err=%0b, actual data=%08h err=%0b",
               name, expected.data, expected.error, actual.data, actual.error);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("[ERROR] %s: expected %0b, actual %0b", name, expected, actual);
    end
  endtask

  // Holds valid and address until the one-cycle ready pulse of the port
  task automatic issue_fetch(input int port, input logic [FETCH_AW-1:0] addr,
                             output fetch_rsp_t rsp);
    @(posedge clk);
    inst_valid[port] <= 1'b1;
    inst_addr[port]  <= addr;
    @(posedge clk);
    while (!inst_ready[port]) @(posedge clk);
    rsp = inst_rsp[port];
    inst_valid[port] <= 1'b0;
  endtask

  task automatic fetch_and_check(input string name, input int port,
                                 input logic [FETCH_AW-1:0] addr);
    fetch_rsp_t rsp;
    issue_fetch(port, addr, rsp);
    check_fetch(name, mem_rule_word(addr), rsp);
  endtask

  task automatic idle_after_reset();
    for (int n = 0; n < 5; n++) begin
      @(posedge clk);
      check_bit("reset_idle inst_ready[0]", 1'b0, inst_ready[0]);
      check_bit("reset_idle inst_ready[1]", 1'b0, inst_ready[1]);
      check_bit("reset_idle mem_req_valid", 1'b0, mem_req_valid);
      check_bit("reset_idle mem_rsp_ready", 1'b1, mem_rsp_ready);
    end
  endtask

  task automatic single_port0_fetch();
    fetch_and_check("single_fetch", 0, 32'h0000_1234);
  endtask

  task automatic line_word_offsets();
    for (int k = 0; k < 4; k++) begin
      fetch_and_check("line_offsets", 1, 32'h0002_0040 + 32'(4 * k));
    end
  endtask

  task automatic dual_port_fetches();
    fork
      fetch_and_check("dual_ports port 0", 0, 32'h0000_3008);
      fetch_and_check("dual_ports port 1", 1, 32'h0000_5c0c);
    join
  endtask

  task automatic error_bit_fetch();
    fetch_and_check("error_bit", 0, 32'h8000_0104);
  endtask

  // Random addresses spread over both ports, which then run side by side
  task automatic random_fetch_run();
    logic [FETCH_AW-1:0] addr_list [NR_FETCH_PORTS][RAND_FETCHES];
    int                  cnt [NR_FETCH_PORTS];
    int                  port;
    cnt[0] = 0;
    cnt[1] = 0;
    for (int n = 0; n < RAND_FETCHES; n++) begin
      port                     = int'($urandom % NR_FETCH_PORTS);
      addr_list[port][cnt[port]] = $urandom & 32'hffff_fffc;
      cnt[port]++;
    end
    fork
      begin
        for (int k = 0; k < cnt[0]; k++) fetch_and_check("random port 0", 0, addr_list[0][k]);
      end
      begin
        for (int k = 0; k < cnt[1]; k++) fetch_and_check("random port 1", 1, addr_list[1][k]);
      end
    join
  endtask

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hb4e7));
    rst_n      = 1'b0;
    inst_valid = '0;
    inst_addr  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    idle_after_reset();
    single_port0_fetch();
    line_word_offsets();
    dual_port_fetches();
    error_bit_fetch();
    random_fetch_run();

    repeat (5) @(posedge clk);
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* project.f */
common/icache_cfg_pkg.sv
common/icache_types_pkg.sv
verilog/spill_register.sv
bypass/bypass_fetch.sv
refill/line_refill.sv
verilog/icache_bypass_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache_bypass.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bypass testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_icache_bypass -o sim_icache_bypass

output=$(./obj_dir/sim_icache_bypass)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
